// ==== src/dcache_pkg.sv ====
package dcache_pkg;

  // CPU word and cache line geometry
  localparam int WORD_WIDTH     = 32;
  localparam int BYTE_WIDTH     = 8;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_WIDTH     = WORD_WIDTH * WORDS_PER_LINE;
  localparam int NUM_LINES      = 4;
  localparam int LINE_IDX_WIDTH = $clog2(NUM_LINES);

  // Byte address split into tag, word offset and byte offset
  localparam int ADDR_WIDTH     = 32;
  localparam int BYTE_OFF_WIDTH = 2;
  localparam int WORD_OFF_WIDTH = 2;
  localparam int TAG_LSB        = WORD_OFF_WIDTH + BYTE_OFF_WIDTH;
  localparam int TAG_WIDTH      = ADDR_WIDTH - TAG_LSB;

  // Register file tag carried with each CPU request
  localparam int REG_IDX_WIDTH  = 5;

  // Backing line memory
  localparam int MEM_LINES      = 64;
  localparam int MEM_IDX_WIDTH  = $clog2(MEM_LINES);
  localparam int MEM_LATENCY    = 4;
  localparam int LAT_CNT_WIDTH  = $clog2(MEM_LATENCY);

  // Cache controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REQ,
    WRITEBACK,
    REFILL,
    RESPOND
  } cache_state_e;

endpackage

// ==== src/mem_req_if.sv ====
`timescale 1ns/1ns

interface mem_req_if;
  import dcache_pkg::*;

  // Requester side
  logic                  req;
  logic [ADDR_WIDTH-1:0] addr;
  logic                  we;
  logic [LINE_WIDTH-1:0] wdata;
  logic                  done;

  // Server side
  logic                  grant;
  logic                  ready;
  logic [LINE_WIDTH-1:0] rdata;

  modport requester (
    output req, addr, we, wdata, done,
    input  grant, ready, rdata
  );

  modport server (
    input  req, addr, we, wdata, done,
    output grant, ready, rdata
  );

endinterface

// ==== src/tag_lookup.sv ====
`timescale 1ns/1ns

module tag_lookup (
  input  logic [dcache_pkg::TAG_WIDTH-1:0]                          tag,
  input  logic [dcache_pkg::NUM_LINES-1:0][dcache_pkg::TAG_WIDTH-1:0] stored_tags,
  input  logic [dcache_pkg::NUM_LINES-1:0]                          valid,
  output logic                                                      hit,
  output logic [dcache_pkg::LINE_IDX_WIDTH-1:0]                     hit_line
);
  import dcache_pkg::*;

  logic [NUM_LINES-1:0] match;

  // One comparator per line, all in parallel
  always_comb
  begin
    for (int i = 0; i < NUM_LINES; i++)
    begin
      match[i] = valid[i] && (stored_tags[i] == tag);
    end
  end

  assign hit = |match;

  // Priority encoder, lowest matching line wins
  always_comb
  begin
    hit_line = '0;
    for (int i = NUM_LINES - 1; i >= 0; i--)
    begin
      if (match[i])
      begin
        hit_line = LINE_IDX_WIDTH'(i);
      end
    end
  end

endmodule

// ==== src/lru_tracker.sv ====
`timescale 1ns/1ns

module lru_tracker (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  touch,
  input  logic [dcache_pkg::LINE_IDX_WIDTH-1:0] touch_line,
  output logic [dcache_pkg::LINE_IDX_WIDTH-1:0] victim
);
  import dcache_pkg::*;

  // Higher count means more recently used
  logic [LINE_IDX_WIDTH-1:0] lru_cnt [NUM_LINES];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < NUM_LINES; i++)
      begin
        lru_cnt[i] <= LINE_IDX_WIDTH'(i);
      end
    end
    else if (touch)
    begin
      for (int i = 0; i < NUM_LINES; i++)
      begin
        if (i == touch_line)
        begin
          lru_cnt[i] <= LINE_IDX_WIDTH'(NUM_LINES - 1);
        end
        else if (lru_cnt[i] >= lru_cnt[touch_line])
        begin
          lru_cnt[i] <= lru_cnt[i] - 1'b1;
        end
      end
    end
  end

  // Smallest count is the victim, ties go to the lower index
  always_comb
  begin
    logic [LINE_IDX_WIDTH-1:0] best;
    best = '0;
    for (int i = 1; i < NUM_LINES; i++)
    begin
      if (lru_cnt[i] < lru_cnt[best])
      begin
        best = LINE_IDX_WIDTH'(i);
      end
    end
    victim = best;
  end

endmodule

// ==== src/dcache.sv ====
`timescale 1ns/1ns

module dcache (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 access,
  input  logic                                 op,
  input  logic                                 byte_op,
  input  logic [dcache_pkg::ADDR_WIDTH-1:0]    address,
  input  logic [dcache_pkg::WORD_WIDTH-1:0]    data_in,
  input  logic [dcache_pkg::REG_IDX_WIDTH-1:0] dest_reg_in,
  input  logic                                 reg_write_in,
  output logic [dcache_pkg::WORD_WIDTH-1:0]    data_out,
  output logic                                 data_ready,
  output logic [dcache_pkg::REG_IDX_WIDTH-1:0] dest_reg_out,
  output logic                                 reg_write_out,
  mem_req_if.requester                         mem
);
  import dcache_pkg::*;

  cache_state_e state;

  // Request captured in IDLE and held until the response
  logic [ADDR_WIDTH-1:0]    req_addr;
  logic                     req_op;
  logic                     req_byte;
  logic [WORD_WIDTH-1:0]    req_data;
  logic [REG_IDX_WIDTH-1:0] req_dest;
  logic                     req_regw;

  logic [NUM_LINES-1:0][TAG_WIDTH-1:0]  tag_array;
  logic [NUM_LINES-1:0][LINE_WIDTH-1:0] line_data;
  logic [NUM_LINES-1:0]                 valid;
  logic [NUM_LINES-1:0]                 dirty;

  logic [LINE_IDX_WIDTH-1:0] line_sel;
  logic [LINE_IDX_WIDTH-1:0] hit_line;
  logic [LINE_IDX_WIDTH-1:0] victim;
  logic [LINE_IDX_WIDTH-1:0] touch_line;
  logic                      hit;
  logic                      victim_dirty;
  logic                      touch;
  logic [TAG_WIDTH-1:0]      req_tag;
  logic [WORD_OFF_WIDTH-1:0] word_sel;
  logic [BYTE_OFF_WIDTH-1:0] byte_sel;

  function automatic logic [LINE_WIDTH-1:0] merge_store(
    input logic [LINE_WIDTH-1:0]     line,
    input logic [WORD_OFF_WIDTH-1:0] wsel,
    input logic [BYTE_OFF_WIDTH-1:0] bsel,
    input logic                      is_byte,
    input logic [WORD_WIDTH-1:0]     wdata
  );
    logic [LINE_WIDTH-1:0] merged;
    merged = line;
    if (is_byte)
    begin
      merged[wsel * WORD_WIDTH + bsel * BYTE_WIDTH +: BYTE_WIDTH] = wdata[BYTE_WIDTH-1:0];
    end
    else
    begin
      merged[wsel * WORD_WIDTH +: WORD_WIDTH] = wdata;
    end
    return merged;
  endfunction

  // Byte loads are zero-extended
  function automatic logic [WORD_WIDTH-1:0] load_value(
    input logic [LINE_WIDTH-1:0]     line,
    input logic [WORD_OFF_WIDTH-1:0] wsel,
    input logic [BYTE_OFF_WIDTH-1:0] bsel,
    input logic                      is_byte
  );
    logic [WORD_WIDTH-1:0] word;
    word = line[wsel * WORD_WIDTH +: WORD_WIDTH];
    if (is_byte)
    begin
      return {{(WORD_WIDTH - BYTE_WIDTH){1'b0}}, word[bsel * BYTE_WIDTH +: BYTE_WIDTH]};
    end
    return word;
  endfunction

  assign req_tag      = req_addr[TAG_LSB +: TAG_WIDTH];
  assign word_sel     = req_addr[BYTE_OFF_WIDTH +: WORD_OFF_WIDTH];
  assign byte_sel     = req_addr[0 +: BYTE_OFF_WIDTH];
  assign victim_dirty = valid[victim] && dirty[victim];

  assign touch      = (state == LOOKUP && hit) || (state == REFILL && mem.ready);
  assign touch_line = (state == LOOKUP) ? hit_line : line_sel;

  assign data_ready    = (state == RESPOND);
  assign dest_reg_out  = req_dest;
  assign reg_write_out = req_regw;

  tag_lookup i_tag_lookup (
    .tag         (req_tag),
    .stored_tags (tag_array),
    .valid       (valid),
    .hit         (hit),
    .hit_line    (hit_line)
  );

  lru_tracker i_lru_tracker (
    .clk        (clk),
    .reset      (reset),
    .touch      (touch),
    .touch_line (touch_line),
    .victim     (victim)
  );

  // Control FSM and line status bits
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state    <= IDLE;
      valid    <= '0;
      dirty    <= '0;
      mem.req  <= 1'b0;
      mem.done <= 1'b0;
    end
    else
    begin
      mem.done <= 1'b0;
      case (state)
        IDLE:
        begin
          if (access)
          begin
            state <= LOOKUP;
          end
        end
        LOOKUP:
        begin
          if (hit)
          begin
            if (!req_op)
            begin
              dirty[hit_line] <= 1'b1;
            end
            state <= RESPOND;
          end
          else
          begin
            mem.req <= 1'b1;
            state   <= REQ;
          end
        end
        REQ:
        begin
          // Write-back was chosen in LOOKUP when the victim is dirty
          if (mem.grant)
          begin
            state <= mem.we ? WRITEBACK : REFILL;
          end
        end
        WRITEBACK:
        begin
          if (mem.ready)
          begin
            dirty[line_sel] <= 1'b0;
            state           <= REFILL;
          end
        end
        REFILL:
        begin
          if (mem.ready)
          begin
            valid[line_sel] <= 1'b1;
            dirty[line_sel] <= !req_op;
            mem.req         <= 1'b0;
            mem.done        <= 1'b1;
            state           <= RESPOND;
          end
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Request capture, arrays and memory payload
  always_ff @(posedge clk)
  begin
    case (state)
      IDLE:
      begin
        if (access)
        begin
          req_addr <= address;
          req_op   <= op;
          req_byte <= byte_op;
          req_data <= data_in;
          req_dest <= dest_reg_in;
          req_regw <= reg_write_in;
        end
      end
      LOOKUP:
      begin
        line_sel <= hit ? hit_line : victim;
        if (hit)
        begin
          data_out <= load_value(line_data[hit_line], word_sel, byte_sel, req_byte);
          if (!req_op)
          begin
            line_data[hit_line] <= merge_store(line_data[hit_line], word_sel, byte_sel,
                                               req_byte, req_data);
          end
        end
        else
        begin
          mem.we    <= victim_dirty;
          mem.wdata <= line_data[victim];
          mem.addr  <= victim_dirty ? {tag_array[victim], {TAG_LSB{1'b0}}}
                                    : {req_tag, {TAG_LSB{1'b0}}};
        end
      end
      WRITEBACK:
      begin
        // Switch to the refill address once the write has landed
        if (mem.ready)
        begin
          mem.we   <= 1'b0;
          mem.addr <= {req_tag, {TAG_LSB{1'b0}}};
        end
      end
      REFILL:
      begin
        if (mem.ready)
        begin
          line_data[line_sel] <= req_op ? mem.rdata
                                        : merge_store(mem.rdata, word_sel, byte_sel,
                                                      req_byte, req_data);
          tag_array[line_sel] <= req_tag;
          data_out            <= load_value(mem.rdata, word_sel, byte_sel, req_byte);
        end
      end
      default:
      begin
      end
    endcase
  end

endmodule

// ==== src/mem_arbiter.sv ====
`timescale 1ns/1ns

module mem_arbiter (
  input  logic         clk,
  input  logic         reset,
  mem_req_if.server    cache,
  mem_req_if.server    fetch,
  mem_req_if.requester mem
);
  import dcache_pkg::*;

  // Owner encoding is 0 for the cache and 1 for the fetch port
  logic busy;
  logic owner;
  logic last_owner;
  logic pick;

  // Alternate when both wait, otherwise serve whoever asks
  assign pick = (cache.req && fetch.req) ? !last_owner : fetch.req;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      busy       <= 1'b0;
      owner      <= 1'b0;
      last_owner <= 1'b1;
    end
    else if (!busy)
    begin
      if (cache.req || fetch.req)
      begin
        busy  <= 1'b1;
        owner <= pick;
      end
    end
    else if (mem.done)
    begin
      busy       <= 1'b0;
      last_owner <= owner;
    end
  end

  // Owner's transaction onto the memory side
  assign mem.req   = busy && (owner ? fetch.req : cache.req);
  assign mem.done  = busy && (owner ? fetch.done : cache.done);
  assign mem.addr  = owner ? fetch.addr : cache.addr;
  assign mem.we    = owner ? fetch.we : cache.we;
  assign mem.wdata = owner ? fetch.wdata : cache.wdata;

  // Responses go back to the owner only
  assign cache.grant = busy && !owner && mem.grant;
  assign fetch.grant = busy && owner && mem.grant;
  assign cache.ready = busy && !owner && mem.ready;
  assign fetch.ready = busy && owner && mem.ready;
  assign cache.rdata = owner ? {LINE_WIDTH{1'b0}} : mem.rdata;
  assign fetch.rdata = owner ? mem.rdata : {LINE_WIDTH{1'b0}};

endmodule

// ==== src/line_memory.sv ====
`timescale 1ns/1ns

module line_memory (
  input  logic      clk,
  input  logic      reset,
  mem_req_if.server bus
);
  import dcache_pkg::*;

  logic [LINE_WIDTH-1:0]    lines [MEM_LINES];
  logic                     busy;
  logic [LAT_CNT_WIDTH-1:0] lat_cnt;
  logic [MEM_IDX_WIDTH-1:0] idx;

  // Line address modulo the memory depth
  assign idx = bus.addr[TAG_LSB +: MEM_IDX_WIDTH];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      bus.grant <= 1'b0;
      bus.ready <= 1'b0;
      bus.rdata <= '0;
      busy      <= 1'b0;
      lat_cnt   <= '0;
      for (int i = 0; i < MEM_LINES; i++)
      begin
        lines[i] <= '0;
      end
    end
    else
    begin
      bus.ready <= 1'b0;

      // Grant follows the request and is released by done
      if (bus.done)
      begin
        bus.grant <= 1'b0;
      end
      else if (bus.req)
      begin
        bus.grant <= 1'b1;
      end

      if (!busy)
      begin
        if (bus.req && bus.grant && !bus.done)
        begin
          busy    <= 1'b1;
          lat_cnt <= LAT_CNT_WIDTH'(1);
        end
      end
      else if (bus.ready)
      begin
        busy <= 1'b0;
      end
      else if (lat_cnt == LAT_CNT_WIDTH'(MEM_LATENCY - 1))
      begin
        bus.ready <= 1'b1;
        bus.rdata <= lines[idx];
        if (bus.we)
        begin
          lines[idx] <= bus.wdata;
        end
      end
      else
      begin
        lat_cnt <= lat_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== src/dcache_top.sv ====
`timescale 1ns/1ns

module dcache_top (
  input  logic                                 clk,
  input  logic                                 reset,
  // CPU request
  input  logic                                 access,
  input  logic                                 op,
  input  logic                                 byte_op,
  input  logic [dcache_pkg::ADDR_WIDTH-1:0]    address,
  input  logic [dcache_pkg::WORD_WIDTH-1:0]    data_in,
  input  logic [dcache_pkg::REG_IDX_WIDTH-1:0] dest_reg_in,
  input  logic                                 reg_write_in,
  // CPU response
  output logic [dcache_pkg::WORD_WIDTH-1:0]    data_out,
  output logic                                 data_ready,
  output logic [dcache_pkg::REG_IDX_WIDTH-1:0] dest_reg_out,
  output logic                                 reg_write_out,
  // Line fetch port
  input  logic                                 fetch_req,
  input  logic [dcache_pkg::ADDR_WIDTH-1:0]    fetch_addr,
  input  logic                                 fetch_done,
  output logic                                 fetch_grant,
  output logic                                 fetch_ready,
  output logic [dcache_pkg::LINE_WIDTH-1:0]    fetch_line
);
  import dcache_pkg::*;

  mem_req_if cache_mem ();
  mem_req_if fetch_mem ();
  mem_req_if arb_mem ();

  // Fetch port only reads
  assign fetch_mem.req   = fetch_req;
  assign fetch_mem.addr  = fetch_addr;
  assign fetch_mem.we    = 1'b0;
  assign fetch_mem.wdata = {LINE_WIDTH{1'b0}};
  assign fetch_mem.done  = fetch_done;
  assign fetch_grant     = fetch_mem.grant;
  assign fetch_ready     = fetch_mem.ready;
  assign fetch_line      = fetch_mem.rdata;

  dcache i_dcache (
    .clk           (clk),
    .reset         (reset),
    .access        (access),
    .op            (op),
    .byte_op       (byte_op),
    .address       (address),
    .data_in       (data_in),
    .dest_reg_in   (dest_reg_in),
    .reg_write_in  (reg_write_in),
    .data_out      (data_out),
    .data_ready    (data_ready),
    .dest_reg_out  (dest_reg_out),
    .reg_write_out (reg_write_out),
    .mem           (cache_mem.requester)
  );

  mem_arbiter i_mem_arbiter (
    .clk   (clk),
    .reset (reset),
    .cache (cache_mem.server),
    .fetch (fetch_mem.server),
    .mem   (arb_mem.requester)
  );

  line_memory i_line_memory (
    .clk   (clk),
    .reset (reset),
    .bus   (arb_mem.server)
  );

endmodule

// ==== tb/dcache_sva.sv ====
`timescale 1ns/1ns

module dcache_sva (
  input logic clk,
  input logic reset,
  input logic data_ready,
  input logic cache_grant,
  input logic fetch_grant,
  input logic mem_req,
  input logic mem_grant,
  input logic mem_done,
  input logic mem_ready,
  input logic mem_busy
);
  import dcache_pkg::*;

  // Line memory begins an access when idle and granted
  logic mem_start;

  // Number of assertion failures so far
  int fail_count = 0;

  assign mem_start = mem_req && mem_grant && !mem_done && !mem_busy;

  data_ready_pulse: assert property (@(posedge clk) disable iff (reset)
    data_ready |=> !data_ready)
  else
  begin
    $error("data_ready held longer than one cycle");
    fail_count++;
  end

  grants_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(cache_grant && fetch_grant))
  else
  begin
    $error("cache and fetch grants high together");
    fail_count++;
  end

  mem_latency: assert property (@(posedge clk) disable iff (reset)
    mem_start |=> !mem_ready [* (MEM_LATENCY - 1)] ##1 mem_ready)
  else
  begin
    $error("line memory ready not at the fixed latency");
    fail_count++;
  end

  reset_quiet: assert property (@(posedge clk)
    reset |-> (!data_ready && !cache_grant && !fetch_grant))
  else
  begin
    $error("response or grant active during reset");
    fail_count++;
  end

endmodule

bind dcache_top dcache_sva i_dcache_sva (
  .clk         (clk),
  .reset       (reset),
  .data_ready  (data_ready),
  .cache_grant (cache_mem.grant),
  .fetch_grant (fetch_grant),
  .mem_req     (arb_mem.req),
  .mem_grant   (arb_mem.grant),
  .mem_done    (arb_mem.done),
  .mem_ready   (arb_mem.ready),
  .mem_busy    (i_line_memory.busy)
);

// ==== tb/dcache_tb.sv ====
`timescale 1ns/1ns

module dcache_tb;
  import dcache_pkg::*;

  logic                     clk;
  logic                     reset;
  logic                     access;
  logic                     op;
  logic                     byte_op;
  logic [ADDR_WIDTH-1:0]    address;
  logic [WORD_WIDTH-1:0]    data_in;
  logic [REG_IDX_WIDTH-1:0] dest_reg_in;
  logic                     reg_write_in;
  logic [WORD_WIDTH-1:0]    data_out;
  logic                     data_ready;
  logic [REG_IDX_WIDTH-1:0] dest_reg_out;
  logic                     reg_write_out;
  logic                     fetch_req;
  logic [ADDR_WIDTH-1:0]    fetch_addr;
  logic                     fetch_done;
  logic                     fetch_grant;
  logic                     fetch_ready;
  logic [LINE_WIDTH-1:0]    fetch_line;

  // Expected memory image, one word per entry, addresses below 0x400
  logic [WORD_WIDTH-1:0] model_mem [256];
  int checks;
  int errors;
  int assert_fails;
  int wait_limit = 100;

  dcache_top i_dcache_top (.*);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check(input logic [LINE_WIDTH-1:0] got, input logic [LINE_WIDTH-1:0] exp,
                       input string msg);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t: %s got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("Timeout: no %s within %0d cycles", what, wait_limit);
    $display("Checks failed");
    $finish;
  endtask

  task automatic report_test(input string name, input int start_errors);
    $display("Test %s done, %0d errors", name, errors - start_errors);
  endtask

  function automatic logic [LINE_WIDTH-1:0] model_line(input logic [ADDR_WIDTH-1:0] addr);
    logic [LINE_WIDTH-1:0] line;
    for (int w = 0; w < WORDS_PER_LINE; w++)
    begin
      line[w * WORD_WIDTH +: WORD_WIDTH] = model_mem[{addr[9:4], 2'(w)}];
    end
    return line;
  endfunction

  // Holds access until data_ready, then drops it for one cycle
  task automatic cpu_request(input logic rd, input logic bop, input logic [ADDR_WIDTH-1:0] addr,
                             input logic [WORD_WIDTH-1:0] wdata,
                             output logic [WORD_WIDTH-1:0] rdata, output int cycles);
    logic [REG_IDX_WIDTH-1:0] dest;
    logic                     regw;
    dest         = REG_IDX_WIDTH'($urandom);
    regw         = 1'($urandom);
    access       = 1'b1;
    op           = rd;
    byte_op      = bop;
    address      = addr;
    data_in      = wdata;
    dest_reg_in  = dest;
    reg_write_in = regw;
    cycles       = 0;
    do
    begin
      @(posedge clk);
      #1;
      cycles++;
    end
    while (!data_ready && cycles < wait_limit);
    if (!data_ready)
    begin
      timeout_abort("data_ready for a CPU request");
    end
    rdata = data_out;
    check(dest_reg_out, dest, $sformatf("dest_reg_out at %0h", addr));
    check(reg_write_out, regw, $sformatf("reg_write_out at %0h", addr));
    access = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic cpu_write(input logic [ADDR_WIDTH-1:0] addr, input logic [WORD_WIDTH-1:0] wdata,
                           input logic bop);
    logic [WORD_WIDTH-1:0] read_back;
    int cycles;
    cpu_request(1'b0, bop, addr, wdata, read_back, cycles);
    if (bop)
    begin
      model_mem[addr[9:2]][addr[1:0] * 8 +: 8] = wdata[7:0];
    end
    else
    begin
      model_mem[addr[9:2]] = wdata;
    end
  endtask

  task automatic cpu_read(input logic [ADDR_WIDTH-1:0] addr, input logic bop, output int cycles);
    logic [WORD_WIDTH-1:0] got;
    logic [WORD_WIDTH-1:0] word;
    logic [WORD_WIDTH-1:0] expected;
    cpu_request(1'b1, bop, addr, '0, got, cycles);
    word     = model_mem[addr[9:2]];
    // Byte loads are zero-extended
    expected = bop ? {24'b0, word[addr[1:0] * 8 +: 8]} : word;
    check(got, expected, $sformatf("read data at %0h", addr));
  endtask

  task automatic fetch_line_read(input logic [ADDR_WIDTH-1:0] addr);
    logic [LINE_WIDTH-1:0] line;
    int waited;
    fetch_req  = 1'b1;
    fetch_addr = addr;
    waited     = 0;
    do
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    while (!fetch_grant && waited < wait_limit);
    if (!fetch_grant)
    begin
      timeout_abort("fetch_grant on the fetch port");
    end
    waited = 0;
    while (!fetch_ready && waited < wait_limit)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!fetch_ready)
    begin
      timeout_abort("fetch_ready on the fetch port");
    end
    line       = fetch_line;
    fetch_req  = 1'b0;
    fetch_done = 1'b1;
    @(posedge clk);
    #1;
    fetch_done = 1'b0;
    check(line, model_line(addr), $sformatf("fetched line at %0h", addr));
  endtask

  task automatic reset_state_reads();
    int start_errors;
    int cycles;
    start_errors = errors;
    check(data_ready, 1'b0, "data_ready after reset");
    check(fetch_grant, 1'b0, "fetch_grant after reset");
    cpu_read(32'h3f8, 1'b0, cycles);
    cpu_read(32'h105, 1'b1, cycles);
    report_test("reset and untouched reads", start_errors);
  endtask

  task automatic word_write_read();
    int start_errors;
    int cycles;
    start_errors = errors;
    cpu_write(32'h048, $urandom, 1'b0);
    cpu_read(32'h048, 1'b0, cycles);
    cpu_read(32'h048, 1'b0, cycles);
    check(cycles, 2, "hit latency in cycles");
    report_test("word write and read", start_errors);
  endtask

  task automatic byte_write_read();
    int start_errors;
    int cycles;
    start_errors = errors;
    cpu_write(32'h080, $urandom, 1'b0);
    cpu_write(32'h082, $urandom, 1'b1);
    cpu_read(32'h080, 1'b0, cycles);
    for (int b = 0; b < 4; b++)
    begin
      cpu_read(32'h080 + b, 1'b1, cycles);
    end
    // Byte store that misses and allocates
    cpu_write(32'h0c7, $urandom, 1'b1);
    cpu_read(32'h0c4, 1'b0, cycles);
    report_test("byte write and read", start_errors);
  endtask

  task automatic lru_eviction_refill();
    int start_errors;
    int cycles;
    start_errors = errors;
    // Five lines into four, so the first one is written back
    for (int i = 0; i < 5; i++)
    begin
      cpu_write(32'h200 + i * 16 + (i % 4) * 4, $urandom, 1'b0);
    end
    for (int w = 0; w < WORDS_PER_LINE; w++)
    begin
      cpu_read(32'h200 + w * 4, 1'b0, cycles);
    end
    report_test("LRU eviction and refill", start_errors);
  endtask

  task automatic fetch_during_miss();
    int start_errors;
    int cycles;
    start_errors = errors;
    fetch_line_read(32'h210);
    // Cache miss with a dirty victim racing the fetch
    fork
      cpu_read(32'h214, 1'b0, cycles);
      fetch_line_read(32'h200);
    join
    report_test("fetch port", start_errors);
  endtask

  initial
  begin
    void'($urandom(32'hdb948c8f));
    reset        = 1'b0;
    access       = 1'b0;
    op           = 1'b0;
    byte_op      = 1'b0;
    address      = '0;
    data_in      = '0;
    dest_reg_in  = '0;
    reg_write_in = 1'b0;
    fetch_req    = 1'b0;
    fetch_addr   = '0;
    fetch_done   = 1'b0;
    checks       = 0;
    errors       = 0;
    assert_fails = 0;
    for (int i = 0; i < 256; i++)
    begin
      model_mem[i] = '0;
    end
    #1;
    reset = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    reset_state_reads();
    word_write_read();
    byte_write_read();
    lru_eviction_refill();
    fetch_during_miss();
    assert_fails = i_dcache_top.i_dcache_sva.fail_count;
    $display("Summary: %0d checks, %0d errors, %0d assertion failures", checks, errors,
             assert_fails);
    if (errors == 0 && assert_fails == 0)
    begin
      $display("All checks passed");
    end
    else
    begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== dcache_sub.f ====
src/dcache_pkg.sv
src/mem_req_if.sv
src/tag_lookup.sv
src/lru_tracker.sv
src/dcache.sv
src/mem_arbiter.sv
src/line_memory.sv
src/dcache_top.sv
tb/dcache_sva.sv
tb/dcache_tb.sv
